/* bus_pkg.sv */
/*
 * Bus package with the widths, vector types and channel structs of the
 * write-address and write-response channels of the outbound port
 */

package bus_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int ADDR_W      = 32;
  localparam int WIDE_ID_W   = 6;
  localparam int NARROW_ID_W = 2;
  // One table entry per narrow ID
  localparam int NUM_IDS     = 2 ** NARROW_ID_W;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [WIDE_ID_W-1:0]   wide_id_t;
  typedef logic [NARROW_ID_W-1:0] narrow_id_t;
  typedef logic [7:0]             len_t;
  typedef logic [1:0]             resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------
  // Channel payloads
  // --------------------
  // Write address as issued by the coherence unit
  typedef struct packed {
    wide_id_t id;
    addr_t    addr;
    len_t     len;
  } aw_wide_t;

  // Write address on the uncore side
  typedef struct packed {
    narrow_id_t id;
    addr_t      addr;
    len_t       len;
  } aw_narrow_t;

  typedef struct packed {
    wide_id_t id;
    resp_t    resp;
  } b_wide_t;

  typedef struct packed {
    narrow_id_t id;
    resp_t      resp;
  } b_narrow_t;

endpackage

/* cdc_pkg.sv */
/*
 * Crossing package with the FIFO depth, gray pointer type and slot
 * arrays of the asynchronous FIFO between cluster and uncore
 */

package cdc_pkg;

  // 2 slots per direction
  localparam int LOG_DEPTH = 1;
  localparam int DEPTH     = 2 ** LOG_DEPTH;

  // Gray-coded pointer with one wrap bit above the slot index
  typedef logic [LOG_DEPTH:0] ptr_t;

  // A pointer exactly DEPTH ahead has the top two gray bits inverted
  localparam ptr_t GRAY_FULL_MASK = ptr_t'(3) << (LOG_DEPTH - 1);

  // Slot arrays exported whole across the boundary
  typedef bus_pkg::aw_narrow_t [DEPTH-1:0] aw_slots_t;
  typedef bus_pkg::b_narrow_t  [DEPTH-1:0] b_slots_t;

  // Binary to gray
  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

/* id_remap.sv */
/*
 * ID remapper that squeezes wide write IDs into a small table index on
 * the way out and restores the wide ID on the returning write response
 */

`timescale 1ns/10ps

module id_remap (
  input  logic                clk_i,
  input  logic                rst_i,
  // Wide request in
  input  bus_pkg::aw_wide_t   slv_req_i,
  input  logic                slv_req_valid_i,
  output logic                slv_req_ready_o,
  // Narrow request out
  output bus_pkg::aw_narrow_t mst_req_o,
  output logic                mst_req_valid_o,
  input  logic                mst_req_ready_i,
  // Narrow response in
  input  bus_pkg::b_narrow_t  mst_rsp_i,
  input  logic                mst_rsp_valid_i,
  output logic                mst_rsp_ready_o,
  // Wide response out
  output bus_pkg::b_wide_t    slv_rsp_o,
  output logic                slv_rsp_valid_o,
  input  logic                slv_rsp_ready_i
);

  logic [bus_pkg::NUM_IDS-1:0] busy_q;
  bus_pkg::wide_id_t           wide_q [bus_pkg::NUM_IDS];

  logic                id_hit;
  logic                any_free;
  bus_pkg::narrow_id_t free_idx;
  logic                req_fire;
  logic                rsp_fire;

  // --------------------
  // Table lookup
  // --------------------
  // Scan from the top so the lowest free entry wins
  always_comb begin
    id_hit   = 1'b0;
    any_free = 1'b0;
    free_idx = '0;
    for (int i = bus_pkg::NUM_IDS - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        any_free = 1'b1;
        free_idx = bus_pkg::narrow_id_t'(i);
      end
      if (busy_q[i] && wide_q[i] == slv_req_i.id) begin
        id_hit = 1'b1;
      end
    end
  end

  // Stall while the ID is in flight or no entry is left
  assign mst_req_valid_o = slv_req_valid_i && !id_hit && any_free;
  assign slv_req_ready_o = mst_req_ready_i && !id_hit && any_free;
  assign mst_req_o       = '{id: free_idx, addr: slv_req_i.addr, len: slv_req_i.len};

  assign req_fire = slv_req_valid_i && slv_req_ready_o;

  // Narrow ID indexes the table on the response path
  assign slv_rsp_o       = '{id: wide_q[mst_rsp_i.id], resp: mst_rsp_i.resp};
  assign slv_rsp_valid_o = mst_rsp_valid_i;
  assign mst_rsp_ready_o = slv_rsp_ready_i;

  assign rsp_fire = mst_rsp_valid_i && mst_rsp_ready_o;

  // --------------------
  // Table update
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= '0;
    end else begin
      if (rsp_fire) begin
        busy_q[mst_rsp_i.id] <= 1'b0;
      end
      if (req_fire) begin
        busy_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      wide_q[free_idx] <= slv_req_i.id;
    end
  end

  // Responses only come back for requests that went out
  assert property (@(posedge clk_i) disable iff (rst_i)
    mst_rsp_valid_i |-> busy_q[mst_rsp_i.id])
    else $error("id_remap: response for idle entry %0d", mst_rsp_i.id);

  // One transaction per wide ID
  for (genvar i = 0; i < bus_pkg::NUM_IDS; i++) begin : gen_uniq_a
    for (genvar j = i + 1; j < bus_pkg::NUM_IDS; j++) begin : gen_uniq_b
      assert property (@(posedge clk_i) disable iff (rst_i)
        !(busy_q[i] && busy_q[j] && wide_q[i] == wide_q[j]))
        else $error("id_remap: entries %0d and %0d share a wide ID", i, j);
    end
  end

endmodule

/* axi_cut.sv */
/*
 * Register cut with a one-entry slice on the request and on the response
 * channel, so no combinational path crosses it in either direction
 */

`timescale 1ns/10ps

module axi_cut (
  input  logic                clk_i,
  input  logic                rst_i,
  // Request
  input  bus_pkg::aw_narrow_t in_req_i,
  input  logic                in_req_valid_i,
  output logic                in_req_ready_o,
  output bus_pkg::aw_narrow_t out_req_o,
  output logic                out_req_valid_o,
  input  logic                out_req_ready_i,
  // Response
  input  bus_pkg::b_narrow_t  in_rsp_i,
  input  logic                in_rsp_valid_i,
  output logic                in_rsp_ready_o,
  output bus_pkg::b_narrow_t  out_rsp_o,
  output logic                out_rsp_valid_o,
  input  logic                out_rsp_ready_i
);

  logic                req_full_q;
  bus_pkg::aw_narrow_t req_data_q;
  logic                rsp_full_q;
  bus_pkg::b_narrow_t  rsp_data_q;

  // --------------------
  // Request slice
  // --------------------
  assign in_req_ready_o  = !req_full_q;
  assign out_req_valid_o = req_full_q;
  assign out_req_o       = req_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_full_q <= 1'b0;
    end else if (in_req_valid_i && !req_full_q) begin
      req_full_q <= 1'b1;
    end else if (out_req_ready_i) begin
      req_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_req_valid_i && !req_full_q) begin
      req_data_q <= in_req_i;
    end
  end

  // --------------------
  // Response slice
  // --------------------
  assign in_rsp_ready_o  = !rsp_full_q;
  assign out_rsp_valid_o = rsp_full_q;
  assign out_rsp_o       = rsp_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_full_q <= 1'b0;
    end else if (in_rsp_valid_i && !rsp_full_q) begin
      rsp_full_q <= 1'b1;
    end else if (out_rsp_ready_i) begin
      rsp_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_rsp_valid_i && !rsp_full_q) begin
      rsp_data_q <= in_rsp_i;
    end
  end

  // Held outputs stay put until taken
  assert property (@(posedge clk_i) disable iff (rst_i)
    out_req_valid_o && !out_req_ready_i |=> out_req_valid_o && $stable(out_req_o))
    else $error("axi_cut: request changed while stalled");

  assert property (@(posedge clk_i) disable iff (rst_i)
    out_rsp_valid_o && !out_rsp_ready_i |=> out_rsp_valid_o && $stable(out_rsp_o))
    else $error("axi_cut: response changed while stalled");

endmodule

/* cdc_src.sv */
/*
 * Crossing source that writes the request FIFO and reads the response
 * FIFO, with gray pointers and two-flop synchronizers
 */

`timescale 1ns/10ps

module cdc_src (
  input  logic                clk_i,
  input  logic                rst_i,
  // Local request and response
  input  bus_pkg::aw_narrow_t req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output bus_pkg::b_narrow_t  rsp_o,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  // Request crossing
  output cdc_pkg::ptr_t       aw_wptr_o,
  output cdc_pkg::aw_slots_t  aw_data_o,
  input  cdc_pkg::ptr_t       aw_rptr_i,
  // Response crossing
  input  cdc_pkg::ptr_t       b_wptr_i,
  input  cdc_pkg::b_slots_t   b_data_i,
  output cdc_pkg::ptr_t       b_rptr_o
);

  cdc_pkg::ptr_t      aw_wptr_bin_q;
  cdc_pkg::ptr_t      aw_wptr_gray_q;
  cdc_pkg::aw_slots_t aw_slots_q;
  cdc_pkg::ptr_t      aw_rptr_s1_q;
  cdc_pkg::ptr_t      aw_rptr_s2_q;

  cdc_pkg::ptr_t      b_rptr_bin_q;
  cdc_pkg::ptr_t      b_rptr_gray_q;
  cdc_pkg::ptr_t      b_wptr_s1_q;
  cdc_pkg::ptr_t      b_wptr_s2_q;

  logic               aw_full;
  logic               b_empty;
  logic               req_fire;
  logic               rsp_fire;
  cdc_pkg::ptr_t      aw_wptr_bin_d;
  cdc_pkg::ptr_t      b_rptr_bin_d;

  // --------------------
  // Synchronizers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_rptr_s1_q <= '0;
      aw_rptr_s2_q <= '0;
      b_wptr_s1_q  <= '0;
      b_wptr_s2_q  <= '0;
    end else begin
      aw_rptr_s1_q <= aw_rptr_i;
      aw_rptr_s2_q <= aw_rptr_s1_q;
      b_wptr_s1_q  <= b_wptr_i;
      b_wptr_s2_q  <= b_wptr_s1_q;
    end
  end

  // --------------------
  // Request writer
  // --------------------
  assign aw_full       = aw_wptr_gray_q == (aw_rptr_s2_q ^ cdc_pkg::GRAY_FULL_MASK);
  assign req_ready_o   = !aw_full;
  assign req_fire      = req_valid_i && req_ready_o;
  assign aw_wptr_bin_d = aw_wptr_bin_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_wptr_bin_q  <= '0;
      aw_wptr_gray_q <= '0;
    end else if (req_fire) begin
      aw_wptr_bin_q  <= aw_wptr_bin_d;
      aw_wptr_gray_q <= cdc_pkg::bin2gray(aw_wptr_bin_d);
    end
  end

  // Slot written on the same edge the pointer moves
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      aw_slots_q[aw_wptr_bin_q[cdc_pkg::LOG_DEPTH-1:0]] <= req_i;
    end
  end

  assign aw_wptr_o = aw_wptr_gray_q;
  assign aw_data_o = aw_slots_q;

  // --------------------
  // Response reader
  // --------------------
  assign b_empty      = b_rptr_gray_q == b_wptr_s2_q;
  assign rsp_valid_o  = !b_empty;
  assign rsp_o        = b_data_i[b_rptr_bin_q[cdc_pkg::LOG_DEPTH-1:0]];
  assign rsp_fire     = rsp_valid_o && rsp_ready_i;
  assign b_rptr_bin_d = b_rptr_bin_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_rptr_bin_q  <= '0;
      b_rptr_gray_q <= '0;
    end else if (rsp_fire) begin
      b_rptr_bin_q  <= b_rptr_bin_d;
      b_rptr_gray_q <= cdc_pkg::bin2gray(b_rptr_bin_d);
    end
  end

  assign b_rptr_o = b_rptr_gray_q;

  // Remote side relies on single-bit pointer steps
  assert property (@(posedge clk_i) disable iff (rst_i)
    !$stable(aw_wptr_gray_q) |-> $countones(aw_wptr_gray_q ^ $past(aw_wptr_gray_q)) == 1)
    else $error("cdc_src: write pointer skipped a gray step");

endmodule

/* bridge_top.sv */
/*
 * Outbound port top that chains the ID remapper, the register cut and
 * the source half of the asynchronous FIFO
 */

`timescale 1ns/10ps

module bridge_top (
  input  logic               clk_i,
  input  logic               rst_i,
  // Cluster side
  input  bus_pkg::aw_wide_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output bus_pkg::b_wide_t   rsp_o,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  // Uncore crossing
  output cdc_pkg::ptr_t      aw_wptr_o,
  output cdc_pkg::aw_slots_t aw_data_o,
  input  cdc_pkg::ptr_t      aw_rptr_i,
  input  cdc_pkg::ptr_t      b_wptr_i,
  input  cdc_pkg::b_slots_t  b_data_i,
  output cdc_pkg::ptr_t      b_rptr_o
);

  // Remapper to cut
  bus_pkg::aw_narrow_t remap_req;
  logic                remap_req_valid;
  logic                remap_req_ready;
  bus_pkg::b_narrow_t  remap_rsp;
  logic                remap_rsp_valid;
  logic                remap_rsp_ready;

  // Cut to crossing
  bus_pkg::aw_narrow_t cut_req;
  logic                cut_req_valid;
  logic                cut_req_ready;
  bus_pkg::b_narrow_t  cut_rsp;
  logic                cut_rsp_valid;
  logic                cut_rsp_ready;

  id_remap i_id_remap (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .slv_req_i       ( req_i           ),
    .slv_req_valid_i ( req_valid_i     ),
    .slv_req_ready_o ( req_ready_o     ),
    .mst_req_o       ( remap_req       ),
    .mst_req_valid_o ( remap_req_valid ),
    .mst_req_ready_i ( remap_req_ready ),
    .mst_rsp_i       ( remap_rsp       ),
    .mst_rsp_valid_i ( remap_rsp_valid ),
    .mst_rsp_ready_o ( remap_rsp_ready ),
    .slv_rsp_o       ( rsp_o           ),
    .slv_rsp_valid_o ( rsp_valid_o     ),
    .slv_rsp_ready_i ( rsp_ready_i     )
  );

  axi_cut i_axi_cut (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .in_req_i        ( remap_req       ),
    .in_req_valid_i  ( remap_req_valid ),
    .in_req_ready_o  ( remap_req_ready ),
    .out_req_o       ( cut_req         ),
    .out_req_valid_o ( cut_req_valid   ),
    .out_req_ready_i ( cut_req_ready   ),
    .in_rsp_i        ( cut_rsp         ),
    .in_rsp_valid_i  ( cut_rsp_valid   ),
    .in_rsp_ready_o  ( cut_rsp_ready   ),
    .out_rsp_o       ( remap_rsp       ),
    .out_rsp_valid_o ( remap_rsp_valid ),
    .out_rsp_ready_i ( remap_rsp_ready )
  );

  cdc_src i_cdc_src (
    .clk_i       ( clk_i         ),
    .rst_i       ( rst_i         ),
    .req_i       ( cut_req       ),
    .req_valid_i ( cut_req_valid ),
    .req_ready_o ( cut_req_ready ),
    .rsp_o       ( cut_rsp       ),
    .rsp_valid_o ( cut_rsp_valid ),
    .rsp_ready_i ( cut_rsp_ready ),
    .aw_wptr_o   ( aw_wptr_o     ),
    .aw_data_o   ( aw_data_o     ),
    .aw_rptr_i   ( aw_rptr_i     ),
    .b_wptr_i    ( b_wptr_i      ),
    .b_data_i    ( b_data_i      ),
    .b_rptr_o    ( b_rptr_o      )
  );

endmodule

/* tb_bridge_top.sv */
/*
 * Testbench for the outbound port that drives wide write requests, plays
 * the uncore half of the asynchronous FIFO and checks with assertions
 */

`timescale 1ns/10ps

module tb_bridge_top;

  typedef struct packed {
    bus_pkg::wide_id_t   wid;
    bus_pkg::aw_narrow_t aw;
  } sent_t;

  typedef struct packed {
    bus_pkg::narrow_id_t nid;
    bus_pkg::b_wide_t    b;
  } due_t;

  logic               clk = 1'b0;
  logic               rst;
  bus_pkg::aw_wide_t  req;
  logic               req_valid;
  logic               req_ready;
  bus_pkg::b_wide_t   rsp;
  logic               rsp_valid;
  logic               rsp_ready;
  cdc_pkg::ptr_t      aw_wptr;
  cdc_pkg::aw_slots_t aw_data;
  cdc_pkg::ptr_t      aw_rptr;
  cdc_pkg::ptr_t      b_wptr;
  cdc_pkg::b_slots_t  b_data;
  cdc_pkg::ptr_t      b_rptr;

  // Reference model of the ID table and outstanding traffic
  sent_t                            sent_q[$];
  due_t                             due_q[$];
  logic [bus_pkg::NUM_IDS-1:0]      busy;
  logic [2**bus_pkg::WIDE_ID_W-1:0] pending_ids;
  bus_pkg::b_wide_t                 exp_rsp;
  bus_pkg::aw_narrow_t              pop_got;
  bus_pkg::aw_narrow_t              pop_exp;
  logic                             pop_chk = 1'b0;
  logic                             pushed_any = 1'b0;
  logic                             hold = 1'b0;
  int                               held_accepts = 0;

  // Remote FIFO side
  cdc_pkg::ptr_t aw_rbin;
  cdc_pkg::ptr_t b_wbin;
  int            pause;
  int            pops = 0;
  int            cyc = 0;
  int            stall_cnt = 0;
  int unsigned   pause_seq [64];
  bit            ready_seq [64];

  int errors = 0;
  int n_req = 0;
  int n_rsp = 0;

  bridge_top UUT (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .req_i       ( req       ),
    .req_valid_i ( req_valid ),
    .req_ready_o ( req_ready ),
    .rsp_o       ( rsp       ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_ready_i ( rsp_ready ),
    .aw_wptr_o   ( aw_wptr   ),
    .aw_data_o   ( aw_data   ),
    .aw_rptr_i   ( aw_rptr   ),
    .b_wptr_i    ( b_wptr    ),
    .b_data_i    ( b_data    ),
    .b_rptr_o    ( b_rptr    )
  );

  always #4 clk = ~clk;

  function automatic cdc_pkg::ptr_t to_gray(input cdc_pkg::ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic cdc_pkg::ptr_t from_gray(input cdc_pkg::ptr_t g);
    cdc_pkg::ptr_t b;
    b = g;
    for (int i = $bits(g) - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Fill level between two gray pointers
  function automatic cdc_pkg::ptr_t ptr_dist(input cdc_pkg::ptr_t wr, input cdc_pkg::ptr_t rd);
    return from_gray(wr) - from_gray(rd);
  endfunction

  // Address bit 2 selects an error response
  function automatic bus_pkg::resp_t resp_for(input bus_pkg::addr_t addr);
    return addr[2] ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
  endfunction

  function automatic bus_pkg::narrow_id_t lowest_free(input logic [bus_pkg::NUM_IDS-1:0] used);
    for (int i = 0; i < bus_pkg::NUM_IDS; i++) begin
      if (!used[i]) begin
        return bus_pkg::narrow_id_t'(i);
      end
    end
    return '0;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic refresh_expect();
    if (due_q.size() != 0) begin
      exp_rsp = due_q[0].b;
    end else begin
      exp_rsp = 'x;
    end
  endtask

  // --------------------
  // Checks
  // --------------------
  assert property (@(posedge clk) $fell(rst) |-> aw_wptr == '0 && b_rptr == '0)
    else report_error("pointers not zero after reset");

  assert property (@(posedge clk) disable iff (rst) !pushed_any |-> !rsp_valid)
    else report_error("response valid before any response was pushed");

  assert property (@(posedge clk) disable iff (rst) pop_chk |-> pop_got == pop_exp)
    else report_error("request on the crossing differs from the scoreboard");

  assert property (@(posedge clk) disable iff (rst) ptr_dist(aw_wptr, aw_rptr) <= 2)
    else report_error("request FIFO overfilled");

  assert property (@(posedge clk) disable iff (rst) hold && held_accepts >= 3 |-> !req_ready)
    else report_error("request ready high with the FIFO held full");

  assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready |-> !pending_ids[req.id])
    else report_error("request accepted with its wide ID still in flight");

  assert property (@(posedge clk) disable iff (rst) req_valid && req_ready |-> !(&busy))
    else report_error("request accepted with the ID table full");

  assert property (@(posedge clk) disable iff (rst) rsp_valid && rsp_ready |-> rsp == exp_rsp)
    else report_error("response ID or code wrong");

  assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp) && $stable(b_rptr))
    else report_error("stalled response moved");

  // --------------------
  // Handshake monitor
  // --------------------
  always @(posedge clk) begin : monitor
    bus_pkg::narrow_id_t nid;
    sent_t               entry;
    due_t                done;
    if (rst) begin
      busy        = '0;
      pending_ids = '0;
      sent_q.delete();
      due_q.delete();
      refresh_expect();
    end else begin
      // Allocation sees the table as it was before this edge
      nid = lowest_free(busy);
      if (rsp_valid && rsp_ready) begin
        if (due_q.size() == 0) begin
          errors++;
          $display("Unexpected response: nothing was outstanding");
        end else begin
          done = due_q.pop_front();
          busy[done.nid] = 1'b0;
          pending_ids[done.b.id] = 1'b0;
          n_rsp++;
          refresh_expect();
        end
      end
      if (req_valid && req_ready) begin
        entry.wid     = req.id;
        entry.aw.id   = nid;
        entry.aw.addr = req.addr;
        entry.aw.len  = req.len;
        sent_q.push_back(entry);
        busy[nid] = 1'b1;
        pending_ids[req.id] = 1'b1;
        n_req++;
        if (hold) begin
          held_accepts++;
        end
      end
    end
  end

  // --------------------
  // Remote FIFO model
  // --------------------
  always @(posedge clk) begin : remote
    sent_t               head;
    due_t                reply;
    bus_pkg::aw_narrow_t got;
    #1;
    pop_chk = 1'b0;
    if (rst) begin
      aw_rbin = '0;
      aw_rptr = '0;
      b_wbin  = '0;
      b_wptr  = '0;
      pause   = 0;
    end else if (pause > 0) begin
      pause--;
    end else if (!hold && aw_wptr != aw_rptr && ptr_dist(b_wptr, b_rptr) < cdc_pkg::DEPTH) begin
      got = aw_data[aw_rbin[cdc_pkg::LOG_DEPTH-1:0]];
      if (sent_q.size() == 0) begin
        errors++;
        $display("Unexpected request on the crossing: nothing was sent");
      end else begin
        head         = sent_q.pop_front();
        pop_got      = got;
        pop_exp      = head.aw;
        pop_chk      = 1'b1;
        reply.nid    = head.aw.id;
        reply.b.id   = head.wid;
        reply.b.resp = resp_for(head.aw.addr);
        due_q.push_back(reply);
        refresh_expect();
      end
      // Answer with the narrow ID as it arrived
      b_data[b_wbin[cdc_pkg::LOG_DEPTH-1:0]] = '{id: got.id, resp: resp_for(got.addr)};
      aw_rbin++;
      aw_rptr = to_gray(aw_rbin);
      b_wbin++;
      b_wptr = to_gray(b_wbin);
      pushed_any = 1'b1;
      pause = pause_seq[pops % 64];
      pops++;
    end
  end

  // Response ready is random unless forced low
  always @(posedge clk) begin
    #1;
    cyc++;
    if (stall_cnt > 0) begin
      stall_cnt--;
      rsp_ready = 1'b0;
    end else begin
      rsp_ready = ready_seq[cyc % 64];
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic send_req(input bus_pkg::wide_id_t id, input bus_pkg::addr_t addr,
                          input bus_pkg::len_t len);
    int waited;
    waited    = 0;
    req       = '{id: id, addr: addr, len: len};
    req_valid = 1'b1;
    @(posedge clk);
    while (!req_ready && waited < 200) begin
      waited++;
      @(posedge clk);
    end
    if (!req_ready) begin
      errors++;
      $display("Timeout: request with ID %0d was never accepted", id);
    end
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_stall();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (req_ready && waited < 30);
    if (req_ready) begin
      errors++;
      $display("Timeout: request ready stayed high with the FIFO held");
    end
    #1;
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while ((sent_q.size() != 0 || due_q.size() != 0) && waited < 400);
    if (sent_q.size() != 0 || due_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d requests never got a response", sent_q.size() + due_q.size());
    end
  endtask

  initial begin
    void'($urandom(32'hd0a3_48ac));
    for (int i = 0; i < 64; i++) begin
      pause_seq[i] = $urandom_range(3, 0);
      ready_seq[i] = ($urandom_range(3, 0) != 0);
    end
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    aw_rptr   = '0;
    b_wptr    = '0;
    b_data    = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Random traffic from a small ID pool so IDs collide
    for (int i = 0; i < 24; i++) begin
      send_req(bus_pkg::wide_id_t'($urandom_range(7, 0)), $urandom, bus_pkg::len_t'($urandom));
    end
    drain_all();

    // Read pointer held until the request side stalls
    hold         = 1'b1;
    held_accepts = 0;
    for (int i = 0; i < 3; i++) begin
      send_req(bus_pkg::wide_id_t'(16 + i), $urandom, bus_pkg::len_t'($urandom));
    end
    fork
      send_req(bus_pkg::wide_id_t'(19), $urandom, bus_pkg::len_t'($urandom));
      begin
        wait_stall();
        repeat (6) @(posedge clk);
        #1;
        hold = 1'b0;
      end
    join
    drain_all();

    // Responses blocked so the table fills and the last ID repeats one still in flight
    stall_cnt = 40;
    for (int i = 0; i < 6; i++) begin
      send_req(bus_pkg::wide_id_t'(i < 5 ? 32 + i : 36), $urandom, bus_pkg::len_t'($urandom));
    end
    drain_all();

    $display("Done: %0d requests, %0d responses, %0d errors", n_req, n_rsp, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* files.f */
bus_pkg.sv
cdc_pkg.sv
id_remap.sv
axi_cut.sv
cdc_src.sv
bridge_top.sv
tb_bridge_top.sv
